// File: rtl/combo_params.svh
`ifndef COMBO_PARAMS_SVH
`define COMBO_PARAMS_SVH

`define DATA_WIDTH 32
`define TAG_WIDTH 6
`define STATION_SIZE 8
`define FREE_WIDTH 16

`define BUS_ADDR_WIDTH 4
`define COMBO_BUS_ADDR 4'h5

`endif

// File: rtl/alu_pkg.sv
package alu_pkg;

  // Integer operations carried from dispatch through the station to the ALUs
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,  // Signed compare
    ALU_SLTU = 4'h9   // Unsigned compare
  } alu_op_t;

endpackage

// File: rtl/rename_pkg.sv
`include "combo_params.svh"

package rename_pkg;

  typedef logic [`TAG_WIDTH-1:0] tag_t;

  localparam tag_t NO_TAG = '0;  // Operand value is already present

  typedef enum logic [1:0] {
    ENTRY_FREE    = 2'd0,
    ENTRY_WAITING = 2'd1,  // At least one source still pending
    ENTRY_READY   = 2'd2
  } entry_state_t;

endpackage

// File: rtl/res_station.sv
`timescale 1ns/1ps

`include "combo_params.svh"

module res_station (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         issue1_valid,
  input  alu_pkg::alu_op_t             issue1_op,
  input  rename_pkg::tag_t             issue1_rrn,
  input  rename_pkg::tag_t             issue1_src1_tag,
  input  logic [`DATA_WIDTH-1:0]       issue1_src1_data,
  input  rename_pkg::tag_t             issue1_src2_tag,
  input  logic [`DATA_WIDTH-1:0]       issue1_src2_data,
  input  logic                         issue1_use_imm,
  input  logic [`DATA_WIDTH-1:0]       issue1_imm,
  input  logic                         issue2_valid,
  input  alu_pkg::alu_op_t             issue2_op,
  input  rename_pkg::tag_t             issue2_rrn,
  input  rename_pkg::tag_t             issue2_src1_tag,
  input  logic [`DATA_WIDTH-1:0]       issue2_src1_data,
  input  rename_pkg::tag_t             issue2_src2_tag,
  input  logic [`DATA_WIDTH-1:0]       issue2_src2_data,
  input  logic                         issue2_use_imm,
  input  logic [`DATA_WIDTH-1:0]       issue2_imm,
  input  logic                         cdb1_valid,
  input  rename_pkg::tag_t             cdb1_rrn,
  input  logic [`DATA_WIDTH-1:0]       cdb1_data,
  input  logic                         cdb2_valid,
  input  rename_pkg::tag_t             cdb2_rrn,
  input  logic [`DATA_WIDTH-1:0]       cdb2_data,
  input  logic [1:0]                   slot_accept,
  output logic [1:0]                   slot_valid,
  output alu_pkg::alu_op_t             slot0_op,
  output alu_pkg::alu_op_t             slot1_op,
  output logic [`DATA_WIDTH-1:0]       slot0_a,
  output logic [`DATA_WIDTH-1:0]       slot0_b,
  output logic [`DATA_WIDTH-1:0]       slot1_a,
  output logic [`DATA_WIDTH-1:0]       slot1_b,
  output rename_pkg::tag_t             slot0_rrn,
  output rename_pkg::tag_t             slot1_rrn,
  output logic [`FREE_WIDTH-1:0]       free_space
);

  localparam int IDX_W = $clog2(`STATION_SIZE);

  rename_pkg::entry_state_t   state_q [`STATION_SIZE];
  alu_pkg::alu_op_t           op_q    [`STATION_SIZE];
  rename_pkg::tag_t           rrn_q   [`STATION_SIZE];
  rename_pkg::tag_t           tag1_q  [`STATION_SIZE];
  rename_pkg::tag_t           tag2_q  [`STATION_SIZE];
  logic [`DATA_WIDTH-1:0]     data1_q [`STATION_SIZE];
  logic [`DATA_WIDTH-1:0]     data2_q [`STATION_SIZE];

  // Operand fields after this cycle's CDB snoop
  rename_pkg::tag_t           tag1_w  [`STATION_SIZE];
  rename_pkg::tag_t           tag2_w  [`STATION_SIZE];
  logic [`DATA_WIDTH-1:0]     data1_w [`STATION_SIZE];
  logic [`DATA_WIDTH-1:0]     data2_w [`STATION_SIZE];

  rename_pkg::tag_t           is1_tag1, is1_tag2, is2_tag1, is2_tag2;
  logic [`DATA_WIDTH-1:0]     is1_data1, is1_data2, is2_data1, is2_data2;

  logic [IDX_W-1:0]           alloc0, alloc1;
  logic [IDX_W-1:0]           rdy0_idx, rdy1_idx, pick1;
  logic                       rdy0_found, rdy1_found;
  logic                       load0, load1, take0, take1;

  function automatic void wake(
    input  rename_pkg::tag_t       tag,
    input  logic [`DATA_WIDTH-1:0] data,
    output rename_pkg::tag_t       new_tag,
    output logic [`DATA_WIDTH-1:0] new_data
  );
    if (cdb1_valid && tag != rename_pkg::NO_TAG && tag == cdb1_rrn) begin
      new_tag  = rename_pkg::NO_TAG;
      new_data = cdb1_data;
    end else if (cdb2_valid && tag != rename_pkg::NO_TAG && tag == cdb2_rrn) begin
      new_tag  = rename_pkg::NO_TAG;
      new_data = cdb2_data;
    end else begin
      new_tag  = tag;
      new_data = data;
    end
  endfunction

  always_comb begin
    wake(issue1_src1_tag, issue1_src1_data, is1_tag1, is1_data1);
    wake(issue1_use_imm ? rename_pkg::NO_TAG : issue1_src2_tag,
         issue1_use_imm ? issue1_imm : issue1_src2_data, is1_tag2, is1_data2);
    wake(issue2_src1_tag, issue2_src1_data, is2_tag1, is2_data1);
    wake(issue2_use_imm ? rename_pkg::NO_TAG : issue2_src2_tag,
         issue2_use_imm ? issue2_imm : issue2_src2_data, is2_tag2, is2_data2);
    for (int i = 0; i < `STATION_SIZE; i++) begin
      wake(tag1_q[i], data1_q[i], tag1_w[i], data1_w[i]);
      wake(tag2_q[i], data2_q[i], tag2_w[i], data2_w[i]);
    end
  end

  // Lowest two free entries, lowest two ready entries and the free count
  always_comb begin
    logic free0_seen;
    logic free1_seen;
    free0_seen = 1'b0;
    free1_seen = 1'b0;
    alloc0     = '0;
    alloc1     = '0;
    rdy0_idx   = '0;
    rdy1_idx   = '0;
    rdy0_found = 1'b0;
    rdy1_found = 1'b0;
    free_space = '0;
    for (int i = 0; i < `STATION_SIZE; i++) begin
      if (state_q[i] == rename_pkg::ENTRY_FREE) begin
        free_space = free_space + `FREE_WIDTH'(1);
        if (!free0_seen) begin
          alloc0     = IDX_W'(i);
          free0_seen = 1'b1;
        end else if (!free1_seen) begin
          alloc1     = IDX_W'(i);
          free1_seen = 1'b1;
        end
      end
      if (state_q[i] == rename_pkg::ENTRY_READY) begin
        if (!rdy0_found) begin
          rdy0_idx   = IDX_W'(i);
          rdy0_found = 1'b1;
        end else if (!rdy1_found) begin
          rdy1_idx   = IDX_W'(i);
          rdy1_found = 1'b1;
        end
      end
    end
  end

  assign load0 = !slot_valid[0] || slot_accept[0];  // Slot empty or draining this edge
  assign load1 = !slot_valid[1] || slot_accept[1];
  assign take0 = load0 && rdy0_found;
  assign pick1 = take0 ? rdy1_idx : rdy0_idx;  // Skip the entry slot 0 is taking
  assign take1 = load1 && (take0 ? rdy1_found : rdy0_found);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `STATION_SIZE; i++) begin
        state_q[i] <= rename_pkg::ENTRY_FREE;
      end
      slot_valid <= 2'b00;
    end else begin
      for (int i = 0; i < `STATION_SIZE; i++) begin
        if (state_q[i] == rename_pkg::ENTRY_WAITING &&
            tag1_w[i] == rename_pkg::NO_TAG && tag2_w[i] == rename_pkg::NO_TAG) begin
          state_q[i] <= rename_pkg::ENTRY_READY;
        end
      end
      if (take0) begin
        state_q[rdy0_idx] <= rename_pkg::ENTRY_FREE;
      end
      if (take1) begin
        state_q[pick1] <= rename_pkg::ENTRY_FREE;
      end
      if (issue1_valid) begin
        state_q[alloc0] <= (is1_tag1 == rename_pkg::NO_TAG && is1_tag2 == rename_pkg::NO_TAG) ?
                           rename_pkg::ENTRY_READY : rename_pkg::ENTRY_WAITING;
      end
      if (issue2_valid) begin
        state_q[alloc1] <= (is2_tag1 == rename_pkg::NO_TAG && is2_tag2 == rename_pkg::NO_TAG) ?
                           rename_pkg::ENTRY_READY : rename_pkg::ENTRY_WAITING;
      end
      if (load0) begin
        slot_valid[0] <= take0;
      end
      if (load1) begin
        slot_valid[1] <= take1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `STATION_SIZE; i++) begin
      if (state_q[i] == rename_pkg::ENTRY_WAITING) begin
        tag1_q[i]  <= tag1_w[i];
        tag2_q[i]  <= tag2_w[i];
        data1_q[i] <= data1_w[i];
        data2_q[i] <= data2_w[i];
      end
    end
    if (issue1_valid) begin
      op_q[alloc0]    <= issue1_op;
      rrn_q[alloc0]   <= issue1_rrn;
      tag1_q[alloc0]  <= is1_tag1;
      tag2_q[alloc0]  <= is1_tag2;
      data1_q[alloc0] <= is1_data1;
      data2_q[alloc0] <= is1_data2;
    end
    if (issue2_valid) begin
      op_q[alloc1]    <= issue2_op;
      rrn_q[alloc1]   <= issue2_rrn;
      tag1_q[alloc1]  <= is2_tag1;
      tag2_q[alloc1]  <= is2_tag2;
      data1_q[alloc1] <= is2_data1;
      data2_q[alloc1] <= is2_data2;
    end
    if (take0) begin
      slot0_op  <= op_q[rdy0_idx];
      slot0_a   <= data1_q[rdy0_idx];
      slot0_b   <= data2_q[rdy0_idx];
      slot0_rrn <= rrn_q[rdy0_idx];
    end
    if (take1) begin
      slot1_op  <= op_q[pick1];
      slot1_a   <= data1_q[pick1];
      slot1_b   <= data2_q[pick1];
      slot1_rrn <= rrn_q[pick1];
    end
  end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

`include "combo_params.svh"

module alu (
  input  alu_pkg::alu_op_t       op,
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  output logic [`DATA_WIDTH-1:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // Only the low 5 bits shift

  always_comb begin
    case (op)
      alu_pkg::ALU_ADD: begin
        result = a + b;
      end
      alu_pkg::ALU_SUB: begin
        result = a - b;
      end
      alu_pkg::ALU_AND: begin
        result = a & b;
      end
      alu_pkg::ALU_OR: begin
        result = a | b;
      end
      alu_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      alu_pkg::ALU_SLL: begin
        result = a << shamt;
      end
      alu_pkg::ALU_SRL: begin
        result = a >> shamt;
      end
      alu_pkg::ALU_SRA: begin
        result = $signed(a) >>> shamt;  // Sign bit fills from the left
      end
      alu_pkg::ALU_SLT: begin
        result = {{(`DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
      end
      alu_pkg::ALU_SLTU: begin
        result = {{(`DATA_WIDTH-1){1'b0}}, a < b};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: rtl/result_router.sv
`timescale 1ns/1ps

`include "combo_params.svh"

module result_router #(
  parameter logic [`BUS_ADDR_WIDTH-1:0] bus_addr = `COMBO_BUS_ADDR
) (
  input  logic [`BUS_ADDR_WIDTH-1:0] cdb1_select,
  input  logic [`BUS_ADDR_WIDTH-1:0] cdb2_select,
  input  logic [1:0]                 slot_valid,
  input  logic [`DATA_WIDTH-1:0]     result0,
  input  logic [`DATA_WIDTH-1:0]     result1,
  input  rename_pkg::tag_t           slot0_rrn,
  input  rename_pkg::tag_t           slot1_rrn,
  output logic                       cdb1_we,
  output logic [`DATA_WIDTH-1:0]     cdb1_out_data,
  output rename_pkg::tag_t           cdb1_out_rrn,
  output logic                       cdb2_we,
  output logic [`DATA_WIDTH-1:0]     cdb2_out_data,
  output rename_pkg::tag_t           cdb2_out_rrn,
  output logic [1:0]                 slot_accept
);

  logic [1:0] granted;
  logic [1:0] bus_enable;
  logic [1:0] res_select;  // Bit n set means bus n+1 carries slot 1

  assign granted = {cdb2_select == bus_addr, cdb1_select == bus_addr};

  always_comb begin
    bus_enable = 2'b00;
    res_select = 2'b00;
    casez ({granted, slot_valid})
      4'b01?1: bus_enable = 2'b01;
      4'b0110: begin
        bus_enable = 2'b01;
        res_select = 2'b01;
      end
      4'b10?1: bus_enable = 2'b10;
      4'b1010: begin
        bus_enable = 2'b10;
        res_select = 2'b10;
      end
      4'b11??: begin
        bus_enable = slot_valid;  // Each slot keeps its own bus
        res_select = 2'b10;
      end
      default: begin
        bus_enable = 2'b00;
      end
    endcase
  end

  assign cdb1_we       = bus_enable[0];
  assign cdb1_out_data = bus_enable[0] ? (res_select[0] ? result1 : result0) : '0;
  assign cdb1_out_rrn  = bus_enable[0] ? (res_select[0] ? slot1_rrn : slot0_rrn) : '0;

  assign cdb2_we       = bus_enable[1];
  assign cdb2_out_data = bus_enable[1] ? (res_select[1] ? result1 : result0) : '0;
  assign cdb2_out_rrn  = bus_enable[1] ? (res_select[1] ? slot1_rrn : slot0_rrn) : '0;

  assign slot_accept[0] = (bus_enable[0] && !res_select[0]) || (bus_enable[1] && !res_select[1]);
  assign slot_accept[1] = (bus_enable[0] && res_select[0]) || (bus_enable[1] && res_select[1]);

endmodule

// File: rtl/alu_combo.sv
`timescale 1ns/1ps

`include "combo_params.svh"

module alu_combo (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        issue1_valid,
  input  alu_pkg::alu_op_t            issue1_op,
  input  rename_pkg::tag_t            issue1_rrn,
  input  rename_pkg::tag_t            issue1_src1_tag,
  input  logic [`DATA_WIDTH-1:0]      issue1_src1_data,
  input  rename_pkg::tag_t            issue1_src2_tag,
  input  logic [`DATA_WIDTH-1:0]      issue1_src2_data,
  input  logic                        issue1_use_imm,
  input  logic [`DATA_WIDTH-1:0]      issue1_imm,
  input  logic                        issue2_valid,
  input  alu_pkg::alu_op_t            issue2_op,
  input  rename_pkg::tag_t            issue2_rrn,
  input  rename_pkg::tag_t            issue2_src1_tag,
  input  logic [`DATA_WIDTH-1:0]      issue2_src1_data,
  input  rename_pkg::tag_t            issue2_src2_tag,
  input  logic [`DATA_WIDTH-1:0]      issue2_src2_data,
  input  logic                        issue2_use_imm,
  input  logic [`DATA_WIDTH-1:0]      issue2_imm,
  input  logic [`BUS_ADDR_WIDTH-1:0]  cdb1_select,
  input  logic                        cdb1_valid,
  input  logic [`DATA_WIDTH-1:0]      cdb1_data,
  input  rename_pkg::tag_t            cdb1_rrn,
  input  logic [`BUS_ADDR_WIDTH-1:0]  cdb2_select,
  input  logic                        cdb2_valid,
  input  logic [`DATA_WIDTH-1:0]      cdb2_data,
  input  rename_pkg::tag_t            cdb2_rrn,
  output logic                        cdb1_we,
  output logic [`DATA_WIDTH-1:0]      cdb1_out_data,
  output rename_pkg::tag_t            cdb1_out_rrn,
  output logic                        cdb2_we,
  output logic [`DATA_WIDTH-1:0]      cdb2_out_data,
  output rename_pkg::tag_t            cdb2_out_rrn,
  output logic [`FREE_WIDTH-1:0]      free_space
);

  logic [1:0]             slot_valid, slot_accept;
  alu_pkg::alu_op_t       slot0_op, slot1_op;
  logic [`DATA_WIDTH-1:0] slot0_a, slot0_b, slot1_a, slot1_b;
  rename_pkg::tag_t       slot0_rrn, slot1_rrn;
  logic [`DATA_WIDTH-1:0] result0, result1;

  res_station u_station (
    .clk(clk), .reset(reset),
    .issue1_valid(issue1_valid), .issue1_op(issue1_op), .issue1_rrn(issue1_rrn),
    .issue1_src1_tag(issue1_src1_tag), .issue1_src1_data(issue1_src1_data),
    .issue1_src2_tag(issue1_src2_tag), .issue1_src2_data(issue1_src2_data),
    .issue1_use_imm(issue1_use_imm), .issue1_imm(issue1_imm),
    .issue2_valid(issue2_valid), .issue2_op(issue2_op), .issue2_rrn(issue2_rrn),
    .issue2_src1_tag(issue2_src1_tag), .issue2_src1_data(issue2_src1_data),
    .issue2_src2_tag(issue2_src2_tag), .issue2_src2_data(issue2_src2_data),
    .issue2_use_imm(issue2_use_imm), .issue2_imm(issue2_imm),
    .cdb1_valid(cdb1_valid), .cdb1_rrn(cdb1_rrn), .cdb1_data(cdb1_data),
    .cdb2_valid(cdb2_valid), .cdb2_rrn(cdb2_rrn), .cdb2_data(cdb2_data),
    .slot_accept(slot_accept), .slot_valid(slot_valid),
    .slot0_op(slot0_op), .slot1_op(slot1_op),
    .slot0_a(slot0_a), .slot0_b(slot0_b), .slot1_a(slot1_a), .slot1_b(slot1_b),
    .slot0_rrn(slot0_rrn), .slot1_rrn(slot1_rrn),
    .free_space(free_space)
  );

  alu u_alu0 (.op(slot0_op), .a(slot0_a), .b(slot0_b), .result(result0));
  alu u_alu1 (.op(slot1_op), .a(slot1_a), .b(slot1_b), .result(result1));

  result_router #(.bus_addr(`COMBO_BUS_ADDR)) u_router (
    .cdb1_select(cdb1_select), .cdb2_select(cdb2_select),
    .slot_valid(slot_valid), .result0(result0), .result1(result1),
    .slot0_rrn(slot0_rrn), .slot1_rrn(slot1_rrn),
    .cdb1_we(cdb1_we), .cdb1_out_data(cdb1_out_data), .cdb1_out_rrn(cdb1_out_rrn),
    .cdb2_we(cdb2_we), .cdb2_out_data(cdb2_out_data), .cdb2_out_rrn(cdb2_out_rrn),
    .slot_accept(slot_accept)
  );

endmodule

// File: verification/alu_combo_tb.sv
`timescale 1ns/1ps

`include "combo_params.svh"

module alu_combo_tb;

  localparam logic [3:0] OWN_ADDR = `COMBO_BUS_ADDR;
  localparam int OWN_RRN_MAX = 47;  // Foreign producers use tags 48 to 63

  logic clk = 1'b0;
  logic reset;
  logic issue1_valid, issue2_valid, issue1_use_imm, issue2_use_imm;
  alu_pkg::alu_op_t issue1_op, issue2_op;
  rename_pkg::tag_t issue1_rrn, issue1_src1_tag, issue1_src2_tag;
  rename_pkg::tag_t issue2_rrn, issue2_src1_tag, issue2_src2_tag;
  logic [`DATA_WIDTH-1:0] issue1_src1_data, issue1_src2_data, issue1_imm;
  logic [`DATA_WIDTH-1:0] issue2_src1_data, issue2_src2_data, issue2_imm;
  logic [3:0] cdb1_select, cdb2_select;
  logic cdb1_valid, cdb2_valid, cdb1_we, cdb2_we;
  logic [`DATA_WIDTH-1:0] cdb1_data, cdb2_data, cdb1_out_data, cdb2_out_data;
  rename_pkg::tag_t cdb1_rrn, cdb2_rrn, cdb1_out_rrn, cdb2_out_rrn;
  logic [`FREE_WIDTH-1:0] free_space;

  // Foreign results from other units on the bus when it is not granted to the DUT
  logic bcast1_valid, bcast2_valid;
  rename_pkg::tag_t bcast1_rrn, bcast2_rrn;
  logic [`DATA_WIDTH-1:0] bcast1_data, bcast2_data;

  logic [31:0] seed = 32'hedcc65f0;
  int mode = 0;  // 0 idle, 1 random traffic, 2 flush foreign tags, 3 drain
  int issued_last = 0;
  int outstanding_count = 0;
  int checks_passed = 0;
  int checks_failed = 0;
  int next_rrn = 1;
  int test_fails;
  int waited;
  bit timed_out = 0;
  bit outstanding [64];
  logic [`DATA_WIDTH-1:0] expected [64];
  bit fopen [64];
  logic [`DATA_WIDTH-1:0] fval [64];

  assign cdb1_valid = (cdb1_select == OWN_ADDR) ? cdb1_we : bcast1_valid;
  assign cdb1_rrn   = (cdb1_select == OWN_ADDR) ? cdb1_out_rrn : bcast1_rrn;
  assign cdb1_data  = (cdb1_select == OWN_ADDR) ? cdb1_out_data : bcast1_data;
  assign cdb2_valid = (cdb2_select == OWN_ADDR) ? cdb2_we : bcast2_valid;
  assign cdb2_rrn   = (cdb2_select == OWN_ADDR) ? cdb2_out_rrn : bcast2_rrn;
  assign cdb2_data  = (cdb2_select == OWN_ADDR) ? cdb2_out_data : bcast2_data;

  alu_combo u_dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() >> 16) % n;  // Upper bits of the LCG are the better ones
  endfunction

  function automatic logic [31:0] alu_model(input alu_pkg::alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      alu_pkg::ALU_ADD:  return a + b;
      alu_pkg::ALU_SUB:  return a - b;
      alu_pkg::ALU_AND:  return a & b;
      alu_pkg::ALU_OR:   return a | b;
      alu_pkg::ALU_XOR:  return a ^ b;
      alu_pkg::ALU_SLL:  return a << b[4:0];
      alu_pkg::ALU_SRL:  return a >> b[4:0];
      alu_pkg::ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
      alu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:           return 32'd0;
    endcase
  endfunction

  // Either a ready value or a pending foreign tag whose value the bus model delivers later
  task automatic pick_operand(output rename_pkg::tag_t tag, output logic [31:0] data,
                              output logic [31:0] value);
    int f;
    if (rand_below(3) == 0) begin
      f = 48 + rand_below(16);
      if (!fopen[f]) begin
        fopen[f] = 1'b1;
        fval[f]  = next_rand();
      end
      tag   = rename_pkg::tag_t'(f);
      data  = next_rand();
      value = fval[f];
    end else begin
      tag   = '0;
      data  = next_rand();
      value = data;
    end
  endtask

  task automatic issue_port(input int k, input bit enable);
    alu_pkg::alu_op_t op;
    rename_pkg::tag_t t1, t2;
    logic [31:0] d1, d2, imm, va, vb;
    bit use_imm;
    bit v;
    int r;
    r = next_rrn;
    v = enable && !outstanding[r];
    op = alu_pkg::alu_op_t'(4'(rand_below(10)));
    pick_operand(t1, d1, va);
    pick_operand(t2, d2, vb);
    use_imm = rand_below(4) == 0;
    imm = next_rand();
    if (use_imm) begin
      vb = imm;  // Source 2 tag and data are ignored in the immediate form
    end
    if (v) begin
      expected[r]    = alu_model(op, va, vb);
      outstanding[r] = 1'b1;
      outstanding_count++;
      issued_last++;
      next_rrn = (next_rrn == OWN_RRN_MAX) ? 1 : next_rrn + 1;
    end
    if (k == 1) begin
      issue1_valid <= v;
      issue1_op <= op;
      issue1_rrn <= rename_pkg::tag_t'(r);
      issue1_src1_tag <= t1;
      issue1_src1_data <= d1;
      issue1_src2_tag <= t2;
      issue1_src2_data <= d2;
      issue1_use_imm <= use_imm;
      issue1_imm <= imm;
    end else begin
      issue2_valid <= v;
      issue2_op <= op;
      issue2_rrn <= rename_pkg::tag_t'(r);
      issue2_src1_tag <= t1;
      issue2_src1_data <= d1;
      issue2_src2_tag <= t2;
      issue2_src2_data <= d2;
      issue2_use_imm <= use_imm;
      issue2_imm <= imm;
    end
  endtask

  function automatic int pick_open(input int excluded);
    int start;
    int f;
    start = rand_below(16);
    for (int i = 0; i < 16; i++) begin
      f = 48 + (start + i) % 16;
      if (fopen[f] && f != excluded) begin
        return f;
      end
    end
    return 0;
  endfunction

  function automatic logic [3:0] pick_select();
    logic [3:0] s;
    if (mode == 2) begin
      return 4'h3;
    end
    if (mode != 1 || rand_below(2) == 0) begin
      return OWN_ADDR;
    end
    s = 4'(rand_below(16));
    return (s == OWN_ADDR) ? 4'h6 : s;
  endfunction

  task automatic drive_buses();
    logic [3:0] s1, s2;
    int f1, f2;
    s1 = pick_select();
    s2 = pick_select();
    f1 = 0;
    f2 = 0;
    if (s1 != OWN_ADDR && (mode == 2 || rand_below(2) == 0)) begin
      f1 = pick_open(0);
    end
    if (s2 != OWN_ADDR && (mode == 2 || rand_below(2) == 0)) begin
      f2 = pick_open(f1);
    end
    cdb1_select <= s1;
    cdb2_select <= s2;
    bcast1_valid <= f1 != 0;
    bcast1_rrn <= rename_pkg::tag_t'(f1);
    bcast1_data <= (f1 != 0) ? fval[f1] : '0;
    bcast2_valid <= f2 != 0;
    bcast2_rrn <= rename_pkg::tag_t'(f2);
    bcast2_data <= (f2 != 0) ? fval[f2] : '0;
    fopen[f1] = 1'b0;
    fopen[f2] = 1'b0;
  endtask

  task automatic check_bus(input int n, input logic we, input logic [3:0] sel,
                           input rename_pkg::tag_t rrn, input logic [31:0] data);
    if (sel != OWN_ADDR) begin
      assert (!we) checks_passed++;
      else begin
        $display("Fail %0t cdb%0d_we expected 0 got %b", $time, n, we);
        checks_failed++;
      end
    end
    if (we) begin
      assert (outstanding[rrn]) checks_passed++;
      else begin
        $display("cdb%0d carries rrn %0d at %0t, which is not outstanding", n, rrn, $time);
        checks_failed++;
      end
      if (outstanding[rrn]) begin
        assert (data == expected[rrn]) checks_passed++;
        else begin
          $display("Fail %0t cdb%0d_out_data expected %h got %h", $time, n, expected[rrn], data);
          checks_failed++;
        end
        outstanding[rrn] = 1'b0;
        outstanding_count--;
      end
    end
  endtask

  always @(posedge clk) begin
    int avail;
    int n;
    if (!reset) begin
      assert (free_space <= `FREE_WIDTH'(`STATION_SIZE)) checks_passed++;
      else begin
        $display("Fail %0t free_space expected <= %0d got %0d", $time, `STATION_SIZE, free_space);
        checks_failed++;
      end
      if (cdb1_we && cdb2_we) begin
        assert (cdb1_out_rrn != cdb2_out_rrn) checks_passed++;
        else begin
          $display("rrn %0d driven on both buses at %0t", cdb1_out_rrn, $time);
          checks_failed++;
        end
      end
      check_bus(1, cdb1_we, cdb1_select, cdb1_out_rrn, cdb1_out_data);
      check_bus(2, cdb2_we, cdb2_select, cdb2_out_rrn, cdb2_out_data);
    end
    // Issues from the last edge are not yet counted in free_space
    avail = int'(free_space) - issued_last;
    n = (mode == 1 && !reset && avail >= 2) ? rand_below(3) : 0;
    issued_last = 0;
    issue_port(1, n >= 1);
    issue_port(2, n >= 2);
    drive_buses();
  end

  function automatic bit any_open();
    for (int f = 48; f < 64; f++) begin
      if (fopen[f]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic report_test(input string name);
    if (checks_failed == test_fails) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, checks_failed - test_fails);
    end
    test_fails = checks_failed;
  endtask

  initial begin
    reset = 1'b1;
    issue1_valid = 1'b0;
    issue2_valid = 1'b0;
    issue1_op = alu_pkg::ALU_ADD;
    issue2_op = alu_pkg::ALU_ADD;
    {issue1_rrn, issue1_src1_tag, issue1_src2_tag} = '0;
    {issue2_rrn, issue2_src1_tag, issue2_src2_tag} = '0;
    {issue1_src1_data, issue1_src2_data, issue1_imm, issue1_use_imm} = '0;
    {issue2_src1_data, issue2_src2_data, issue2_imm, issue2_use_imm} = '0;
    cdb1_select = OWN_ADDR;
    cdb2_select = OWN_ADDR;
    {bcast1_valid, bcast1_rrn, bcast1_data} = '0;
    {bcast2_valid, bcast2_rrn, bcast2_data} = '0;
    test_fails = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (free_space == `FREE_WIDTH'(`STATION_SIZE)) checks_passed++;
    else begin
      $display("Fail %0t free_space expected %0d got %0d", $time, `STATION_SIZE, free_space);
      checks_failed++;
    end
    assert (!cdb1_we) checks_passed++;
    else begin
      $display("Fail %0t cdb1_we expected 0 got %b", $time, cdb1_we);
      checks_failed++;
    end
    assert (!cdb2_we) checks_passed++;
    else begin
      $display("Fail %0t cdb2_we expected 0 got %b", $time, cdb2_we);
      checks_failed++;
    end
    report_test("reset_state");

    mode = 1;
    repeat (600) @(negedge clk);
    report_test("random_traffic");

    // Hand out every pending foreign value, then give both buses to the DUT
    mode = 2;
    waited = 0;
    while (any_open() && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (any_open()) begin
      $display("timeout while broadcasting foreign results");
      timed_out = 1'b1;
    end
    mode = 3;
    waited = 0;
    while ((outstanding_count != 0 || free_space != `FREE_WIDTH'(`STATION_SIZE)) &&
           waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (outstanding_count != 0) begin
      $display("timeout with %0d instructions still outstanding", outstanding_count);
      timed_out = 1'b1;
    end
    assert (free_space == `FREE_WIDTH'(`STATION_SIZE)) checks_passed++;
    else begin
      $display("Fail %0t free_space expected %0d got %0d", $time, `STATION_SIZE, free_space);
      checks_failed++;
    end
    report_test("drain");

    $display("checks passed %0d failed %0d", checks_passed, checks_failed);
    if (timed_out || checks_failed != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/rename_pkg.sv
rtl/res_station.sv
rtl/alu.sv
rtl/result_router.sv
rtl/alu_combo.sv
verification/alu_combo_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module alu_combo_tb -o Valu_combo_tb

out=$(./obj_dir/Valu_combo_tb)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi
